/* rtl/axil_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface axil_if;
    import ls_bus_pkg::*;

    // write address
    logic               aw_valid;
    logic               aw_ready;
    logic [ADDR_W-1:0]  aw_addr;
    logic [SIZE_W-1:0]  aw_size;
    logic [PROT_W-1:0]  aw_prot;

    // write data
    logic               w_valid;
    logic               w_ready;
    logic [XLEN-1:0]    w_data;
    logic [STRB_W-1:0]  w_strb;

    // write response
    logic               b_valid;
    logic               b_ready;
    axi_resp_e          b_resp;

    // read address
    logic               ar_valid;
    logic               ar_ready;
    logic [ADDR_W-1:0]  ar_addr;
    logic [SIZE_W-1:0]  ar_size;
    logic [PROT_W-1:0]  ar_prot;

    // read data
    logic               r_valid;
    logic               r_ready;
    logic [XLEN-1:0]    r_data;
    axi_resp_e          r_resp;

    modport master (
        output aw_valid, aw_addr, aw_size, aw_prot, w_valid, w_data, w_strb, b_ready,
        output ar_valid, ar_addr, ar_size, ar_prot, r_ready,
        input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
    );

    modport slave (
        input  aw_valid, aw_addr, aw_size, aw_prot, w_valid, w_data, w_strb, b_ready,
        input  ar_valid, ar_addr, ar_size, ar_prot, r_ready,
        output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
    );

endinterface

`default_nettype wire

/* rtl/ls_axi_crossbar.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_axi_crossbar (
    input  wire                             clk,
    input  wire                             arst_n_i,
    axil_if.slave                           up,

    output logic                            mem_aw_valid_o,
    input  wire                             mem_aw_ready_i,
    output logic [ls_bus_pkg::ADDR_W-1:0]   mem_aw_addr_o,
    output logic [ls_bus_pkg::SIZE_W-1:0]   mem_aw_size_o,
    output logic [ls_bus_pkg::PROT_W-1:0]   mem_aw_prot_o,
    output logic                            mem_w_valid_o,
    input  wire                             mem_w_ready_i,
    output logic [ls_bus_pkg::XLEN-1:0]     mem_w_data_o,
    output logic [ls_bus_pkg::STRB_W-1:0]   mem_w_strb_o,
    input  wire                             mem_b_valid_i,
    output logic                            mem_b_ready_o,
    input  wire ls_bus_pkg::axi_resp_e      mem_b_resp_i,
    output logic                            mem_ar_valid_o,
    input  wire                             mem_ar_ready_i,
    output logic [ls_bus_pkg::ADDR_W-1:0]   mem_ar_addr_o,
    output logic [ls_bus_pkg::SIZE_W-1:0]   mem_ar_size_o,
    output logic [ls_bus_pkg::PROT_W-1:0]   mem_ar_prot_o,
    input  wire                             mem_r_valid_i,
    output logic                            mem_r_ready_o,
    input  wire [ls_bus_pkg::XLEN-1:0]      mem_r_data_i,
    input  wire ls_bus_pkg::axi_resp_e      mem_r_resp_i,

    output logic                            mmio_aw_valid_o,
    input  wire                             mmio_aw_ready_i,
    output logic [ls_bus_pkg::ADDR_W-1:0]   mmio_aw_addr_o,
    output logic [ls_bus_pkg::SIZE_W-1:0]   mmio_aw_size_o,
    output logic [ls_bus_pkg::PROT_W-1:0]   mmio_aw_prot_o,
    output logic                            mmio_w_valid_o,
    input  wire                             mmio_w_ready_i,
    output logic [ls_bus_pkg::XLEN-1:0]     mmio_w_data_o,
    output logic [ls_bus_pkg::STRB_W-1:0]   mmio_w_strb_o,
    input  wire                             mmio_b_valid_i,
    output logic                            mmio_b_ready_o,
    input  wire ls_bus_pkg::axi_resp_e      mmio_b_resp_i,
    output logic                            mmio_ar_valid_o,
    input  wire                             mmio_ar_ready_i,
    output logic [ls_bus_pkg::ADDR_W-1:0]   mmio_ar_addr_o,
    output logic [ls_bus_pkg::SIZE_W-1:0]   mmio_ar_size_o,
    output logic [ls_bus_pkg::PROT_W-1:0]   mmio_ar_prot_o,
    input  wire                             mmio_r_valid_i,
    output logic                            mmio_r_ready_o,
    input  wire [ls_bus_pkg::XLEN-1:0]      mmio_r_data_i,
    input  wire ls_bus_pkg::axi_resp_e      mmio_r_resp_i
);
    import ls_bus_pkg::*;

    logic w_busy_q;                             // write route locked
    logic w_sel_q;
    logic r_busy_q;                             // read route locked
    logic r_sel_q;
    logic w_sel;                                // 1 selects mmio
    logic r_sel;

    assign w_sel = w_busy_q ? w_sel_q : (up.aw_addr >= MMIO_BASE);
    assign r_sel = r_busy_q ? r_sel_q : (up.ar_addr >= MMIO_BASE);

    // hold the route from the first address cycle until the response is taken
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            w_busy_q <= 1'b0;
            w_sel_q  <= 1'b0;
            r_busy_q <= 1'b0;
            r_sel_q  <= 1'b0;
        end else begin
            if (up.b_valid && up.b_ready) begin
                w_busy_q <= 1'b0;
            end else if (up.aw_valid && !w_busy_q) begin
                w_busy_q <= 1'b1;
                w_sel_q  <= w_sel;
            end
            if (up.r_valid && up.r_ready) begin
                r_busy_q <= 1'b0;
            end else if (up.ar_valid && !r_busy_q) begin
                r_busy_q <= 1'b1;
                r_sel_q  <= r_sel;
            end
        end
    end

    // forward direction, only the chosen port sees anything
    assign mem_aw_valid_o  = up.aw_valid & ~w_sel;
    assign mem_aw_addr_o   = w_sel ? '0 : up.aw_addr;
    assign mem_aw_size_o   = w_sel ? '0 : up.aw_size;
    assign mem_aw_prot_o   = w_sel ? '0 : up.aw_prot;
    assign mem_w_valid_o   = up.w_valid & ~w_sel;
    assign mem_w_data_o    = w_sel ? '0 : up.w_data;
    assign mem_w_strb_o    = w_sel ? '0 : up.w_strb;
    assign mem_b_ready_o   = up.b_ready & ~w_sel;
    assign mem_ar_valid_o  = up.ar_valid & ~r_sel;
    assign mem_ar_addr_o   = r_sel ? '0 : up.ar_addr;
    assign mem_ar_size_o   = r_sel ? '0 : up.ar_size;
    assign mem_ar_prot_o   = r_sel ? '0 : up.ar_prot;
    assign mem_r_ready_o   = up.r_ready & ~r_sel;

    assign mmio_aw_valid_o = up.aw_valid & w_sel;
    assign mmio_aw_addr_o  = w_sel ? up.aw_addr : '0;
    assign mmio_aw_size_o  = w_sel ? up.aw_size : '0;
    assign mmio_aw_prot_o  = w_sel ? up.aw_prot : '0;
    assign mmio_w_valid_o  = up.w_valid & w_sel;
    assign mmio_w_data_o   = w_sel ? up.w_data : '0;
    assign mmio_w_strb_o   = w_sel ? up.w_strb : '0;
    assign mmio_b_ready_o  = up.b_ready & w_sel;
    assign mmio_ar_valid_o = up.ar_valid & r_sel;
    assign mmio_ar_addr_o  = r_sel ? up.ar_addr : '0;
    assign mmio_ar_size_o  = r_sel ? up.ar_size : '0;
    assign mmio_ar_prot_o  = r_sel ? up.ar_prot : '0;
    assign mmio_r_ready_o  = up.r_ready & r_sel;

    // return direction
    assign up.aw_ready = w_sel ? mmio_aw_ready_i : mem_aw_ready_i;
    assign up.w_ready  = w_sel ? mmio_w_ready_i  : mem_w_ready_i;
    assign up.b_valid  = w_sel ? mmio_b_valid_i  : mem_b_valid_i;
    assign up.b_resp   = w_sel ? mmio_b_resp_i   : mem_b_resp_i;
    assign up.ar_ready = r_sel ? mmio_ar_ready_i : mem_ar_ready_i;
    assign up.r_valid  = r_sel ? mmio_r_valid_i  : mem_r_valid_i;
    assign up.r_data   = r_sel ? mmio_r_data_i   : mem_r_data_i;
    assign up.r_resp   = r_sel ? mmio_r_resp_i   : mem_r_resp_i;

endmodule

`default_nettype wire

/* rtl/ls_axi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_axi_master (
    input  wire                             clk,
    input  wire                             arst_n_i,
    input  wire                             req_i,
    input  wire                             we_i,
    input  wire ls_bus_pkg::ls_size_e       size_i,
    input  wire [ls_bus_pkg::ADDR_W-1:0]    addr_i,
    input  wire [ls_bus_pkg::XLEN-1:0]      wdata_i,
    output logic                            ack_o,
    output logic [ls_bus_pkg::XLEN-1:0]     rdata_o,
    output logic                            err_o,
    axil_if.master                          bus
);
    import ls_bus_pkg::*;

    ls_state_e          state_q;
    ls_state_e          state_d;
    logic               aw_pend_q;              // aw not yet accepted
    logic               w_pend_q;               // w not yet accepted
    logic [ADDR_W-1:0]  addr_q;
    logic [XLEN-1:0]    wdata_q;
    ls_size_e           size_q;
    logic [OFF_W-1:0]   off;
    logic               aw_done;
    logic               w_done;
    logic               start;
    logic [STRB_W-1:0]  strb_base;
    logic [XLEN-1:0]    rd_shift;
    logic [XLEN-1:0]    rd_lane;

    assign off     = addr_q[OFF_W-1:0];
    assign aw_done = bus.aw_valid & bus.aw_ready;
    assign w_done  = bus.w_valid & bus.w_ready;
    assign start   = (state_q == ST_IDLE) & req_i;

    always_comb begin
        case (size_q)
            SZ_BYTE: strb_base = 8'h01;
            SZ_HALF: strb_base = 8'h03;
            SZ_WORD: strb_base = 8'h0f;
            default: strb_base = 8'hff;
        endcase
    end

    assign bus.aw_valid = aw_pend_q;
    assign bus.aw_addr  = addr_q;
    assign bus.aw_size  = axi_size(size_q);
    assign bus.aw_prot  = 3'b000;               // unprivileged, secure, data
    assign bus.w_valid  = w_pend_q;
    assign bus.w_data   = wdata_q << {off, 3'b000};   // move into the byte lane
    assign bus.w_strb   = strb_base << off;
    assign bus.b_ready  = (state_q == ST_WRESP);
    assign bus.ar_valid = (state_q == ST_RADDR);
    assign bus.ar_addr  = addr_q;
    assign bus.ar_size  = axi_size(size_q);
    assign bus.ar_prot  = 3'b000;
    assign bus.r_ready  = (state_q == ST_RDATA);

    // addressed lane down to bit 0, then zero-extend
    assign rd_shift = bus.r_data >> {off, 3'b000};

    always_comb begin
        case (size_q)
            SZ_BYTE: rd_lane = XLEN'(rd_shift[7:0]);
            SZ_HALF: rd_lane = XLEN'(rd_shift[15:0]);
            SZ_WORD: rd_lane = XLEN'(rd_shift[31:0]);
            default: rd_lane = rd_shift;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_i) begin
                    state_d = we_i ? ST_WADDR : ST_RADDR;
                end
            end
            ST_WADDR: begin
                if ((aw_done || !aw_pend_q) && (w_done || !w_pend_q)) begin
                    state_d = ST_WRESP;
                end
            end
            ST_WRESP: begin
                if (bus.b_valid) begin
                    state_d = ST_ACK;
                end
            end
            ST_RADDR: begin
                if (bus.ar_ready) begin
                    state_d = ST_RDATA;
                end
            end
            ST_RDATA: begin
                if (bus.r_valid) begin
                    state_d = ST_ACK;
                end
            end
            ST_ACK: begin
                if (!req_i) begin                   // four-phase return to zero
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            rdata_o   <= '0;
            err_o     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start && we_i) begin
                aw_pend_q <= 1'b1;
                w_pend_q  <= 1'b1;
            end else begin
                if (aw_done) begin
                    aw_pend_q <= 1'b0;
                end
                if (w_done) begin
                    w_pend_q <= 1'b0;
                end
            end
            if (bus.b_valid && bus.b_ready) begin
                rdata_o <= '0;
                err_o   <= (bus.b_resp != RESP_OKAY);
            end
            if (bus.r_valid && bus.r_ready) begin
                rdata_o <= rd_lane;
                err_o   <= (bus.r_resp != RESP_OKAY);
            end
        end
    end

    // request fields held for the whole transaction
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr_i;
            size_q  <= size_i;
            wdata_q <= wdata_i;
        end
    end

    assign ack_o = (state_q == ST_ACK);

endmodule

`default_nettype wire

/* rtl/ls_bus_pkg.sv */
`default_nettype none

package ls_bus_pkg;

    localparam int XLEN   = 64;
    localparam int ADDR_W = 64;
    localparam int STRB_W = XLEN / 8;
    localparam int OFF_W  = 3;                  // byte offset inside a doubleword
    localparam int SIZE_W = 3;                  // axi size field
    localparam int PROT_W = 3;

    localparam logic [ADDR_W-1:0] MMIO_BASE = 64'h0000_0000_a000_0000;

    // encoding matches the axi size field, log2 of the byte count
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_HALF  = 2'd1,
        SZ_WORD  = 2'd2,
        SZ_DWORD = 2'd3
    } ls_size_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_WADDR = 3'd1,
        ST_WRESP = 3'd2,
        ST_RADDR = 3'd3,
        ST_RDATA = 3'd4,
        ST_ACK   = 3'd5
    } ls_state_e;

    function automatic logic [SIZE_W-1:0] axi_size(input ls_size_e sz);
        return {1'b0, sz};                      // zero-extend to the bus field
    endfunction

endpackage

`default_nettype wire

/* rtl/ls_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_bus_top (
    input  wire                             clk,
    input  wire                             arst_n_i,

    // load/store request, four-phase req/ack
    input  wire                             req_i,
    input  wire                             we_i,
    input  wire ls_bus_pkg::ls_size_e       size_i,
    input  wire [ls_bus_pkg::ADDR_W-1:0]    addr_i,
    input  wire [ls_bus_pkg::XLEN-1:0]      wdata_i,
    output logic                            ack_o,
    output logic [ls_bus_pkg::XLEN-1:0]     rdata_o,
    output logic                            err_o,

    // memory port
    output logic                            mem_aw_valid_o,
    input  wire                             mem_aw_ready_i,
    output logic [ls_bus_pkg::ADDR_W-1:0]   mem_aw_addr_o,
    output logic [ls_bus_pkg::SIZE_W-1:0]   mem_aw_size_o,
    output logic [ls_bus_pkg::PROT_W-1:0]   mem_aw_prot_o,
    output logic                            mem_w_valid_o,
    input  wire                             mem_w_ready_i,
    output logic [ls_bus_pkg::XLEN-1:0]     mem_w_data_o,
    output logic [ls_bus_pkg::STRB_W-1:0]   mem_w_strb_o,
    input  wire                             mem_b_valid_i,
    output logic                            mem_b_ready_o,
    input  wire ls_bus_pkg::axi_resp_e      mem_b_resp_i,
    output logic                            mem_ar_valid_o,
    input  wire                             mem_ar_ready_i,
    output logic [ls_bus_pkg::ADDR_W-1:0]   mem_ar_addr_o,
    output logic [ls_bus_pkg::SIZE_W-1:0]   mem_ar_size_o,
    output logic [ls_bus_pkg::PROT_W-1:0]   mem_ar_prot_o,
    input  wire                             mem_r_valid_i,
    output logic                            mem_r_ready_o,
    input  wire [ls_bus_pkg::XLEN-1:0]      mem_r_data_i,
    input  wire ls_bus_pkg::axi_resp_e      mem_r_resp_i,

    // mmio port
    output logic                            mmio_aw_valid_o,
    input  wire                             mmio_aw_ready_i,
    output logic [ls_bus_pkg::ADDR_W-1:0]   mmio_aw_addr_o,
    output logic [ls_bus_pkg::SIZE_W-1:0]   mmio_aw_size_o,
    output logic [ls_bus_pkg::PROT_W-1:0]   mmio_aw_prot_o,
    output logic                            mmio_w_valid_o,
    input  wire                             mmio_w_ready_i,
    output logic [ls_bus_pkg::XLEN-1:0]     mmio_w_data_o,
    output logic [ls_bus_pkg::STRB_W-1:0]   mmio_w_strb_o,
    input  wire                             mmio_b_valid_i,
    output logic                            mmio_b_ready_o,
    input  wire ls_bus_pkg::axi_resp_e      mmio_b_resp_i,
    output logic                            mmio_ar_valid_o,
    input  wire                             mmio_ar_ready_i,
    output logic [ls_bus_pkg::ADDR_W-1:0]   mmio_ar_addr_o,
    output logic [ls_bus_pkg::SIZE_W-1:0]   mmio_ar_size_o,
    output logic [ls_bus_pkg::PROT_W-1:0]   mmio_ar_prot_o,
    input  wire                             mmio_r_valid_i,
    output logic                            mmio_r_ready_o,
    input  wire [ls_bus_pkg::XLEN-1:0]      mmio_r_data_i,
    input  wire ls_bus_pkg::axi_resp_e      mmio_r_resp_i
);

    axil_if bus_up ();                          // bridge to crossbar

    // request side ports match by name
    ls_axi_master u_master (
        .bus (bus_up.master),
        .*
    );

    // mem_* and mmio_* ports match by name
    ls_axi_crossbar u_xbar (
        .up  (bus_up.slave),
        .*
    );

endmodule

`default_nettype wire

/* tb.f */
rtl/ls_bus_pkg.sv
rtl/axil_if.sv
rtl/ls_axi_master.sv
rtl/ls_axi_crossbar.sv
rtl/ls_bus_top.sv
tests/axil_slave_model.sv
tests/tb_ls_bus.sv

/* tests/axil_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_slave_model #(
    parameter logic [ls_bus_pkg::ADDR_W-1:0] BASE  = '0,
    parameter int                            DEPTH = 256
) (
    input  wire                             clk,
    input  wire [127:0]                     delays_i,   // 64 wait counts of 2 bits each
    output logic [ls_bus_pkg::SIZE_W-1:0]   size_o,     // size of the last address taken
    output logic [ls_bus_pkg::PROT_W-1:0]   prot_o,     // prot of the last address taken
    axil_if.slave                           bus
);
    import ls_bus_pkg::*;

    localparam int ACCEPT_TIMEOUT = 200;

    logic [XLEN-1:0] mem [0:DEPTH-1];
    int              dly_idx;

    function automatic logic in_range(input logic [ADDR_W-1:0] a);
        return (a >= BASE) && ((a - BASE) < 64'(DEPTH * 8));
    endfunction

    function automatic int word_index(input logic [ADDR_W-1:0] a);
        return int'((a - BASE) >> 3);
    endfunction

    // 0 to 3 idle cycles, always ends 1 ns after an edge
    task automatic stall();
        int n;
        n = int'(delays_i[2*dly_idx +: 2]);
        dly_idx = (dly_idx + 1) % 64;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // valid is up, it is taken on the first edge with ready high
    task automatic wait_accept(input logic is_read);
        int cycles;
        cycles = 0;
        while (!(is_read ? bus.r_ready : bus.b_ready) && cycles < ACCEPT_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= ACCEPT_TIMEOUT) begin
            $display("slave model at %h: the response was never accepted", BASE);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   data;
        logic [STRB_W-1:0] strb;
        logic              ok;
        int                i;
        bus.aw_ready = 1'b0;
        bus.w_ready  = 1'b0;
        bus.b_valid  = 1'b0;
        bus.b_resp   = RESP_OKAY;
        bus.ar_ready = 1'b0;
        bus.r_valid  = 1'b0;
        bus.r_data   = '0;
        bus.r_resp   = RESP_OKAY;
        size_o       = '1;                          // no address seen yet
        prot_o       = '1;
        dly_idx      = 0;
        for (i = 0; i < DEPTH; i++) begin
            mem[i] = BASE + ADDR_W'(i * 8);         // each doubleword holds its own address
        end
        forever begin
            @(posedge clk);
            #1;
            if (bus.aw_valid && bus.w_valid) begin
                addr   = bus.aw_addr;
                data   = bus.w_data;
                strb   = bus.w_strb;
                size_o = bus.aw_size;
                prot_o = bus.aw_prot;
                ok     = in_range(addr);
                stall();
                bus.aw_ready = 1'b1;
                bus.w_ready  = 1'b1;
                @(posedge clk);
                #1;
                bus.aw_ready = 1'b0;
                bus.w_ready  = 1'b0;
                if (ok) begin
                    for (i = 0; i < STRB_W; i++) begin
                        if (strb[i]) begin
                            mem[word_index(addr)][8*i +: 8] = data[8*i +: 8];
                        end
                    end
                end
                stall();
                bus.b_resp  = ok ? RESP_OKAY : RESP_SLVERR;
                bus.b_valid = 1'b1;
                wait_accept(1'b0);
                bus.b_valid = 1'b0;
            end else if (bus.ar_valid) begin
                addr   = bus.ar_addr;
                size_o = bus.ar_size;
                prot_o = bus.ar_prot;
                ok     = in_range(addr);
                stall();
                bus.ar_ready = 1'b1;
                @(posedge clk);
                #1;
                bus.ar_ready = 1'b0;
                stall();
                bus.r_data  = ok ? mem[word_index(addr)] : '0;
                bus.r_resp  = ok ? RESP_OKAY : RESP_SLVERR;
                bus.r_valid = 1'b1;
                wait_accept(1'b1);
                bus.r_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/ls_bus_cases.txt */
# name op(1=write) size(0=b 1=h 2=w 3=d) addr wdata expected_rdata expected_err
# unwritten doublewords read back their own byte address
dw_wr       1 3 0000000000000100 1122334455667788 0000000000000000 0
dw_rd       0 3 0000000000000100 0000000000000000 1122334455667788 0
byte_wr_1   1 0 0000000000000101 ffffffffffffffaa 0000000000000000 0
half_wr_6   1 1 0000000000000106 ffffffffffffbeef 0000000000000000 0
dw_rd_mix   0 3 0000000000000100 0000000000000000 beef33445566aa88 0
word_wr_0   1 2 0000000000000100 ffffffffcafef00d 0000000000000000 0
dw_rd_word  0 3 0000000000000100 0000000000000000 beef3344cafef00d 0
byte_rd_5   0 0 0000000000000105 0000000000000000 0000000000000033 0
byte_rd_7   0 0 0000000000000107 0000000000000000 00000000000000be 0
half_rd_2   0 1 0000000000000102 0000000000000000 000000000000cafe 0
half_rd_6   0 1 0000000000000106 0000000000000000 000000000000beef 0
word_rd_4   0 2 0000000000000104 0000000000000000 00000000beef3344 0
mem_last    0 3 00000000000007f8 0000000000000000 00000000000007f8 0
mmio_wr     1 3 00000000a0000008 deadbeef00c0ffee 0000000000000000 0
mmio_rd     0 3 00000000a0000008 0000000000000000 deadbeef00c0ffee 0
mmio_rd_w4  0 2 00000000a000000c 0000000000000000 00000000deadbeef 0
mem_rd_8    0 3 0000000000000008 0000000000000000 0000000000000008 0
mmio_init   0 3 00000000a0000010 0000000000000000 00000000a0000010 0
mem_wr_oob  1 3 0000000000000800 0123456789abcdef 0000000000000000 1
mem_rd_oob  0 3 0000000000000800 0000000000000000 0000000000000000 1
mmio_wr_oob 1 2 00000000a0000080 0000000012345678 0000000000000000 1
mmio_rd_oob 0 0 00000000a0000080 0000000000000000 0000000000000000 1
rd_after    0 3 0000000000000100 0000000000000000 beef3344cafef00d 0

/* tests/tb_ls_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ls_bus;
    import ls_bus_pkg::*;

    localparam int          HALF_PERIOD  = 10;
    localparam int          RESET_CYCLES = 8;
    localparam int          ACK_TIMEOUT  = 200;
    localparam int          IN_DELAY     = 1;
    localparam logic [31:0] SEED         = 32'hdca7_cb3f;
    localparam string       CASE_FILE    = "tests/ls_bus_cases.txt";

    logic              clk;
    logic              arst_n;
    logic              req;
    logic              we;
    ls_size_e          size;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
    logic              ack;
    logic [XLEN-1:0]   rdata;
    logic              err;
    logic [127:0]      mem_delays;
    logic [127:0]      mmio_delays;
    logic [SIZE_W-1:0] mem_size;
    logic [PROT_W-1:0] mem_prot;
    logic [SIZE_W-1:0] mmio_size;
    logic [PROT_W-1:0] mmio_prot;
    int                errors;

    axil_if mem_bus ();
    axil_if mmio_bus ();

    ls_bus_top u_dut (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .req_i           (req),
        .we_i            (we),
        .size_i          (size),
        .addr_i          (addr),
        .wdata_i         (wdata),
        .ack_o           (ack),
        .rdata_o         (rdata),
        .err_o           (err),
        .mem_aw_valid_o  (mem_bus.aw_valid),
        .mem_aw_ready_i  (mem_bus.aw_ready),
        .mem_aw_addr_o   (mem_bus.aw_addr),
        .mem_aw_size_o   (mem_bus.aw_size),
        .mem_aw_prot_o   (mem_bus.aw_prot),
        .mem_w_valid_o   (mem_bus.w_valid),
        .mem_w_ready_i   (mem_bus.w_ready),
        .mem_w_data_o    (mem_bus.w_data),
        .mem_w_strb_o    (mem_bus.w_strb),
        .mem_b_valid_i   (mem_bus.b_valid),
        .mem_b_ready_o   (mem_bus.b_ready),
        .mem_b_resp_i    (mem_bus.b_resp),
        .mem_ar_valid_o  (mem_bus.ar_valid),
        .mem_ar_ready_i  (mem_bus.ar_ready),
        .mem_ar_addr_o   (mem_bus.ar_addr),
        .mem_ar_size_o   (mem_bus.ar_size),
        .mem_ar_prot_o   (mem_bus.ar_prot),
        .mem_r_valid_i   (mem_bus.r_valid),
        .mem_r_ready_o   (mem_bus.r_ready),
        .mem_r_data_i    (mem_bus.r_data),
        .mem_r_resp_i    (mem_bus.r_resp),
        .mmio_aw_valid_o (mmio_bus.aw_valid),
        .mmio_aw_ready_i (mmio_bus.aw_ready),
        .mmio_aw_addr_o  (mmio_bus.aw_addr),
        .mmio_aw_size_o  (mmio_bus.aw_size),
        .mmio_aw_prot_o  (mmio_bus.aw_prot),
        .mmio_w_valid_o  (mmio_bus.w_valid),
        .mmio_w_ready_i  (mmio_bus.w_ready),
        .mmio_w_data_o   (mmio_bus.w_data),
        .mmio_w_strb_o   (mmio_bus.w_strb),
        .mmio_b_valid_i  (mmio_bus.b_valid),
        .mmio_b_ready_o  (mmio_bus.b_ready),
        .mmio_b_resp_i   (mmio_bus.b_resp),
        .mmio_ar_valid_o (mmio_bus.ar_valid),
        .mmio_ar_ready_i (mmio_bus.ar_ready),
        .mmio_ar_addr_o  (mmio_bus.ar_addr),
        .mmio_ar_size_o  (mmio_bus.ar_size),
        .mmio_ar_prot_o  (mmio_bus.ar_prot),
        .mmio_r_valid_i  (mmio_bus.r_valid),
        .mmio_r_ready_o  (mmio_bus.r_ready),
        .mmio_r_data_i   (mmio_bus.r_data),
        .mmio_r_resp_i   (mmio_bus.r_resp)
    );

    axil_slave_model #(.BASE('0), .DEPTH(256)) u_mem (
        .clk      (clk),
        .delays_i (mem_delays),
        .size_o   (mem_size),
        .prot_o   (mem_prot),
        .bus      (mem_bus.slave)
    );

    axil_slave_model #(.BASE(MMIO_BASE), .DEPTH(16)) u_mmio (
        .clk      (clk),
        .delays_i (mmio_delays),
        .size_o   (mmio_size),
        .prot_o   (mmio_prot),
        .bus      (mmio_bus.slave)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic abort_run(input string why);
        errors++;
        $display("%0s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check(input string test, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error: %0s expected %h actual %h", test, expected, actual));
        end
    endtask

    // ack plus every valid and ready the DUT drives
    task automatic check_idle(input string test);
        check(test, '0, XLEN'({ack, err,
                               mem_bus.aw_valid, mem_bus.w_valid, mem_bus.ar_valid,
                               mem_bus.b_ready, mem_bus.r_ready,
                               mmio_bus.aw_valid, mmio_bus.w_valid, mmio_bus.ar_valid,
                               mmio_bus.b_ready, mmio_bus.r_ready}));
    endtask

    task automatic wait_ack(input logic level, input string test);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #IN_DELAY;
            cycles++;
        end
        if (ack !== level) begin
            abort_run($sformatf("%0s: ack_o did not %0s within %0d cycles",
                                test, level ? "rise" : "fall", ACK_TIMEOUT));
        end
    endtask

    // one full four-phase handshake
    task automatic run_access(input string test, input logic is_write, input ls_size_e sz,
                              input logic [ADDR_W-1:0] a, input logic [XLEN-1:0] wd,
                              input logic [XLEN-1:0] exp_rdata, input logic exp_err);
        req   = 1'b1;
        we    = is_write;
        size  = sz;
        addr  = a;
        wdata = wd;
        wait_ack(1'b1, test);
        if (!is_write && !exp_err) begin
            check(test, exp_rdata, rdata);
        end
        check({test, " err_o"}, XLEN'(exp_err), XLEN'(err));
        // axi size is log2 of the byte count, same as the case file column
        if (a >= MMIO_BASE) begin
            check({test, " size"}, XLEN'(sz), XLEN'(mmio_size));
            check({test, " prot"}, '0, XLEN'(mmio_prot));
        end else begin
            check({test, " size"}, XLEN'(sz), XLEN'(mem_size));
            check({test, " prot"}, '0, XLEN'(mem_prot));
        end
        req = 1'b0;
        wait_ack(1'b0, test);
    endtask

    initial begin
        int                fd;
        int                fields;
        int                cases_run;
        int                i;
        int unsigned       seed_ret;
        string             line;
        string             name;
        logic              op;
        logic [1:0]        sz;
        logic [ADDR_W-1:0] a;
        logic [XLEN-1:0]   wd;
        logic [XLEN-1:0]   rd;
        logic              e;
        arst_n    = 1'b0;
        req       = 1'b0;
        we        = 1'b0;
        size      = SZ_BYTE;
        addr      = '0;
        wdata     = '0;
        errors    = 0;
        cases_run = 0;
        seed_ret  = $urandom(SEED);
        for (i = 0; i < 64; i++) begin
            mem_delays[2*i +: 2]  = 2'($urandom_range(3, 0));
            mmio_delays[2*i +: 2] = 2'($urandom_range(3, 0));
        end
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #IN_DELAY;
            check_idle("reset");
        end
        arst_n = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #IN_DELAY;
            check_idle("idle after reset");
        end
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            abort_run({"could not open the case file ", CASE_FILE});
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;                           // blank or column notes
            end
            fields = $sscanf(line, "%s %h %h %h %h %h %h", name, op, sz, a, wd, rd, e);
            if (fields != 7) begin
                abort_run({"malformed line in the case file: ", line});
            end
            run_access(name, op, ls_size_e'(sz), a, wd, rd, e);
            cases_run++;
        end
        $fclose(fd);
        if (cases_run == 0) begin
            abort_run("the case file held no cases");
        end
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
